// File: sim/umai_write_cases.txt
// one write per line: port select, address, length, 512-bit data (lane 1 upper, lane 0 lower)
// rows 4 to 15 form the group run with ip ready held low
0 00001000 01 0070c0ffee12345d0060c0ffee12345d0050c0ffee12345d0040c0ffee12345d0030c0ffee12345d0020c0ffee12345d0010c0ffee12345d0000c0ffee12345d
0 00001040 3f 0173c96e1d2b4a580163c96e1d2b4a580153c96e1d2b4a580143c96e1d2b4a580133c96e1d2b4a580123c96e1d2b4a580113c96e1d2b4a580103c96e1d2b4a58
0 00001080 10 0270c0ffee12345d0260c0ffee12345d0250c0ffee12345d0240c0ffee12345d0230c0ffee12345d0220c0ffee12345d0210c0ffee12345d0200c0ffee12345d
0 000010c0 00 0373c96e1d2b4a580363c96e1d2b4a580353c96e1d2b4a580343c96e1d2b4a580333c96e1d2b4a580323c96e1d2b4a580313c96e1d2b4a580303c96e1d2b4a58
1 8000a000 05 0470c0ffee12345d0460c0ffee12345d0450c0ffee12345d0440c0ffee12345d0430c0ffee12345d0420c0ffee12345d0410c0ffee12345d0400c0ffee12345d
1 8000a100 2a 0573c96e1d2b4a580563c96e1d2b4a580553c96e1d2b4a580543c96e1d2b4a580533c96e1d2b4a580523c96e1d2b4a580513c96e1d2b4a580503c96e1d2b4a58
1 8000a200 11 0670c0ffee12345d0660c0ffee12345d0650c0ffee12345d0640c0ffee12345d0630c0ffee12345d0620c0ffee12345d0610c0ffee12345d0600c0ffee12345d
1 8000a300 3e 0773c96e1d2b4a580763c96e1d2b4a580753c96e1d2b4a580743c96e1d2b4a580733c96e1d2b4a580723c96e1d2b4a580713c96e1d2b4a580703c96e1d2b4a58
1 8000a400 07 0870c0ffee12345d0860c0ffee12345d0850c0ffee12345d0840c0ffee12345d0830c0ffee12345d0820c0ffee12345d0810c0ffee12345d0800c0ffee12345d
1 8000a500 20 0973c96e1d2b4a580963c96e1d2b4a580953c96e1d2b4a580943c96e1d2b4a580933c96e1d2b4a580923c96e1d2b4a580913c96e1d2b4a580903c96e1d2b4a58
1 8000a600 19 0a70c0ffee12345d0a60c0ffee12345d0a50c0ffee12345d0a40c0ffee12345d0a30c0ffee12345d0a20c0ffee12345d0a10c0ffee12345d0a00c0ffee12345d
1 8000a700 33 0b73c96e1d2b4a580b63c96e1d2b4a580b53c96e1d2b4a580b43c96e1d2b4a580b33c96e1d2b4a580b23c96e1d2b4a580b13c96e1d2b4a580b03c96e1d2b4a58
1 8000a800 0b 0c70c0ffee12345d0c60c0ffee12345d0c50c0ffee12345d0c40c0ffee12345d0c30c0ffee12345d0c20c0ffee12345d0c10c0ffee12345d0c00c0ffee12345d
1 8000a900 3f 0d73c96e1d2b4a580d63c96e1d2b4a580d53c96e1d2b4a580d43c96e1d2b4a580d33c96e1d2b4a580d23c96e1d2b4a580d13c96e1d2b4a580d03c96e1d2b4a58
1 8000aa00 01 0e70c0ffee12345d0e60c0ffee12345d0e50c0ffee12345d0e40c0ffee12345d0e30c0ffee12345d0e20c0ffee12345d0e10c0ffee12345d0e00c0ffee12345d
1 8000ab00 24 0f73c96e1d2b4a580f63c96e1d2b4a580f53c96e1d2b4a580f43c96e1d2b4a580f33c96e1d2b4a580f23c96e1d2b4a580f13c96e1d2b4a580f03c96e1d2b4a58
0 0001ff00 08 1070c0ffee12345d1060c0ffee12345d1050c0ffee12345d1040c0ffee12345d1030c0ffee12345d1020c0ffee12345d1010c0ffee12345d1000c0ffee12345d
0 0001ff40 15 1173c96e1d2b4a581163c96e1d2b4a581153c96e1d2b4a581143c96e1d2b4a581133c96e1d2b4a581123c96e1d2b4a581113c96e1d2b4a581103c96e1d2b4a58
0 0001ff80 2c 1270c0ffee12345d1260c0ffee12345d1250c0ffee12345d1240c0ffee12345d1230c0ffee12345d1220c0ffee12345d1210c0ffee12345d1200c0ffee12345d
0 0001ffc0 3a 1373c96e1d2b4a581363c96e1d2b4a581353c96e1d2b4a581343c96e1d2b4a581333c96e1d2b4a581323c96e1d2b4a581313c96e1d2b4a581303c96e1d2b4a58

// File: list.f
logic/umai_afifo_pkg.sv
logic/umai_async_fifo.sv
logic/umai_bus_accept.sv
logic/umai_ip_port_steer.sv
logic/umai_arb_afifo.sv
sim/tb_umai_arb_afifo.sv

// File: run_sim.sh
#!/bin/sh
# build and run the write bridge testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
  --top-module tb_umai_arb_afifo -f list.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: sim/tb_umai_arb_afifo.sv
`timescale 1ns/1ps
`default_nettype none

module tb_umai_arb_afifo
  import umai_afifo_pkg::*;
();

  localparam int NUM_CASES   = 20;
  localparam int HOLD_FIRST  = 4; // first row of the group run with ip ready held low
  localparam int CYCLE_LIMIT = 200 * NUM_CASES + 500;

  logic                    i_reset;
  logic                    i_bus_clk = 1'b0;
  logic                    i_ip_clk = 1'b0;
  logic                    i_ip_sel;
  logic                    i_int_mst_wcmd_valid;
  logic                    o_int_mst_wcmd_ready;
  logic [CMD_ADDR_W-1:0]   i_int_mst_wcmd_addr;
  logic [CMD_LEN_W-1:0]    i_int_mst_wcmd_len;
  logic                    i_int_mst_wvalid;
  logic                    o_int_mst_wready;
  logic [DATA_W-1:0]       i_int_mst_wdata;
  logic [NUM_IP_PORTS-1:0] o_ext_mst_wcmd_valid;
  logic [NUM_IP_PORTS-1:0] i_ext_mst_wcmd_ready;
  logic [CMD_ADDR_W-1:0]   o_ext_mst_wcmd_addr [NUM_IP_PORTS];
  logic [CMD_LEN_W-1:0]    o_ext_mst_wcmd_len  [NUM_IP_PORTS];
  logic [NUM_IP_PORTS-1:0] o_ext_mst_wvalid;
  logic [NUM_IP_PORTS-1:0] i_ext_mst_wready;
  logic [DATA_W-1:0]       o_ext_mst_wdata     [NUM_IP_PORTS];

  // four words per row for select, address, length and data
  logic [DATA_W-1:0]       cases_mem [NUM_CASES*4];

  // expected traffic in file order
  int                      cmd_id_q [$];
  logic [CMD_ADDR_W-1:0]   exp_addr_q [$];
  logic [CMD_LEN_W-1:0]    exp_len_q [$];
  int                      data_id_q [$];
  logic [DATA_W-1:0]       exp_data_q [$];

  logic sel_next;
  logic hold_ready;
  int   cmd_sent;
  int   data_sent;
  int   cmd_errors;
  int   data_errors;
  int   other_errors;

  umai_arb_afifo dut (.*);

  initial begin : bus_clock
    forever #2 i_bus_clk = ~i_bus_clk;
  end

  initial begin : ip_clock
    forever #3 i_ip_clk = ~i_ip_clk;
  end

  function automatic logic row_sel(input int row);
    return cases_mem[4*row][0];
  endfunction

  function automatic logic [CMD_ADDR_W-1:0] row_addr(input int row);
    return cases_mem[4*row+1][CMD_ADDR_W-1:0];
  endfunction

  function automatic logic [CMD_LEN_W-1:0] row_len(input int row);
    return cases_mem[4*row+2][CMD_LEN_W-1:0];
  endfunction

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------
  task automatic check_cmd(input string name,
                           input logic [CMD_ADDR_W-1:0] exp_addr,
                           input logic [CMD_LEN_W-1:0] exp_len,
                           input logic [CMD_ADDR_W-1:0] act_addr,
                           input logic [CMD_LEN_W-1:0] act_len);
    if (act_addr !== exp_addr || act_len !== exp_len) begin
      cmd_errors++;
      $display("Error %s: expected addr %h len %h, actual addr %h len %h",
               name, exp_addr, exp_len, act_addr, act_len);
    end
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] exp_beat,
                            input logic [DATA_W-1:0] act_beat);
    if (act_beat !== exp_beat) begin
      data_errors++;
      $display("Error %s: expected %h, actual %h", name, exp_beat, act_beat);
    end
  endtask

  task automatic check_level(input string name, input logic exp_lvl, input logic act_lvl);
    if (act_lvl !== exp_lvl) begin
      other_errors++;
      $display("Error %s: expected %b, actual %b", name, exp_lvl, act_lvl);
    end
  endtask

  task automatic check_count(input string name, input int exp_cnt, input int act_cnt);
    if (act_cnt != exp_cnt) begin
      other_errors++;
      $display("Error %s: expected %0d, actual %0d", name, exp_cnt, act_cnt);
    end
  endtask

  // --------------------------------------------------
  // bus side drivers
  // --------------------------------------------------
  task automatic send_cmd(input int row);
    repeat ($urandom_range(0, 2)) @(negedge i_bus_clk); // random gap
    cmd_id_q.push_back(row);
    exp_addr_q.push_back(row_addr(row));
    exp_len_q.push_back(row_len(row));
    i_int_mst_wcmd_addr  = row_addr(row);
    i_int_mst_wcmd_len   = row_len(row);
    i_int_mst_wcmd_valid = 1'b1;
    while (!o_int_mst_wcmd_ready) @(negedge i_bus_clk);
    @(negedge i_bus_clk); // taken on the rising edge in between
    i_int_mst_wcmd_valid = 1'b0;
    cmd_sent++;
  endtask

  task automatic send_data(input int row);
    repeat ($urandom_range(0, 2)) @(negedge i_bus_clk);
    data_id_q.push_back(row);
    exp_data_q.push_back(cases_mem[4*row+3]);
    i_int_mst_wdata  = cases_mem[4*row+3];
    i_int_mst_wvalid = 1'b1;
    while (!o_int_mst_wready) @(negedge i_bus_clk);
    @(negedge i_bus_clk);
    i_int_mst_wvalid = 1'b0;
    data_sent++;
  endtask

  task automatic check_backpressure(input int cmd_base, input int data_base);
    int waited;
    waited = 0;
    while ((cmd_sent - cmd_base < CMD_FIFO_DEPTH || data_sent - data_base < DATA_FIFO_DEPTH)
           && waited < 400) begin
      @(negedge i_bus_clk);
      waited++;
    end
    repeat (20) @(negedge i_bus_clk); // nothing more may get in
    check_count("commands accepted with ip ready low", CMD_FIFO_DEPTH, cmd_sent - cmd_base);
    check_count("beats accepted with ip ready low", DATA_FIFO_DEPTH, data_sent - data_base);
    check_level("wcmd_ready with command fifo full", 1'b0, o_int_mst_wcmd_ready);
    check_level("wready with lanes full", 1'b0, o_int_mst_wready);
    hold_ready = 1'b0;
  endtask

  task automatic run_group(input int first, input int last);
    int cmd_base;
    int data_base;
    cmd_base   = cmd_sent;
    data_base  = data_sent;
    hold_ready = (first == HOLD_FIRST);
    fork
      begin
        for (int r = first; r <= last; r++) send_cmd(r);
      end
      begin
        for (int r = first; r <= last; r++) send_data(r);
      end
      begin
        if (first == HOLD_FIRST) check_backpressure(cmd_base, data_base);
      end
    join
  endtask

  task automatic wait_idle();
    while (cmd_id_q.size() != 0 || data_id_q.size() != 0) @(negedge i_bus_clk);
    repeat (4) @(negedge i_ip_clk); // last pops settle
  endtask

  task automatic switch_port(input logic sel);
    sel_next = sel;
    repeat (2) @(negedge i_ip_clk);
    @(negedge i_bus_clk);
  endtask

  // --------------------------------------------------
  // ip side readies and port monitor
  // --------------------------------------------------
  task automatic observe_ports();
    logic p;
    logic u;
    p = i_ip_sel;
    u = ~i_ip_sel;
    check_level("unselected port wcmd_valid", 1'b0, o_ext_mst_wcmd_valid[u]);
    check_level("unselected port wvalid", 1'b0, o_ext_mst_wvalid[u]);
    check_cmd("unselected port command", '0, '0, o_ext_mst_wcmd_addr[u], o_ext_mst_wcmd_len[u]);
    check_data("unselected port data", '0, o_ext_mst_wdata[u]);
    if (o_ext_mst_wcmd_valid[p] && i_ext_mst_wcmd_ready[p]) begin
      if (cmd_id_q.size() == 0) begin
        other_errors++;
        $display("a command came out on port %0d with no write pending", p);
      end else begin
        check_cmd($sformatf("write %0d command", cmd_id_q.pop_front()),
                  exp_addr_q.pop_front(), exp_len_q.pop_front(),
                  o_ext_mst_wcmd_addr[p], o_ext_mst_wcmd_len[p]);
      end
    end
    if (o_ext_mst_wvalid[p] && i_ext_mst_wready[p]) begin
      if (data_id_q.size() == 0) begin
        other_errors++;
        $display("a data beat came out on port %0d with no write pending", p);
      end else begin
        check_data($sformatf("write %0d data", data_id_q.pop_front()),
                   exp_data_q.pop_front(), o_ext_mst_wdata[p]);
      end
    end
  endtask

  initial begin : ip_side
    forever begin
      @(negedge i_ip_clk);
      i_ip_sel = sel_next;
      if (hold_ready) begin
        i_ext_mst_wcmd_ready = '0;
        i_ext_mst_wready     = '0;
      end else begin
        for (int p = 0; p < NUM_IP_PORTS; p++) begin
          i_ext_mst_wcmd_ready[p] = ($urandom_range(0, 3) != 0);
          i_ext_mst_wready[p]     = ($urandom_range(0, 3) != 0);
        end
      end
      #1; // outputs settle well before the rising edge
      observe_ports();
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge i_bus_clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d bus cycles", CYCLE_LIMIT);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin : main
    int first;
    int last;
    void'($urandom(32'h8732));
    i_reset              = 1'b1;
    i_ip_sel             = 1'b0;
    i_int_mst_wcmd_valid = 1'b0;
    i_int_mst_wcmd_addr  = '0;
    i_int_mst_wcmd_len   = '0;
    i_int_mst_wvalid     = 1'b0;
    i_int_mst_wdata      = '0;
    i_ext_mst_wcmd_ready = '0;
    i_ext_mst_wready     = '0;
    sel_next             = 1'b0;
    hold_ready           = 1'b0;
    cmd_sent             = 0;
    data_sent            = 0;
    cmd_errors           = 0;
    data_errors          = 0;
    other_errors         = 0;
    $readmemh("sim/umai_write_cases.txt", cases_mem);

    repeat (16) @(negedge i_bus_clk);
    i_reset = 1'b0;
    @(negedge i_bus_clk);
    check_level("wcmd_ready after reset", 1'b1, o_int_mst_wcmd_ready);
    check_level("wready after reset", 1'b1, o_int_mst_wready);
    for (int p = 0; p < NUM_IP_PORTS; p++) begin
      check_level($sformatf("port %0d wcmd_valid after reset", p), 1'b0, o_ext_mst_wcmd_valid[p]);
      check_level($sformatf("port %0d wvalid after reset", p), 1'b0, o_ext_mst_wvalid[p]);
    end

    // one group per run of rows with the same select
    first = 0;
    while (first < NUM_CASES) begin
      last = first;
      while (last + 1 < NUM_CASES && row_sel(last + 1) == row_sel(first)) last++;
      switch_port(row_sel(first));
      run_group(first, last);
      wait_idle();
      first = last + 1;
    end

    $display("errors: command %0d, data %0d, other %0d", cmd_errors, data_errors, other_errors);
    if (cmd_errors + data_errors + other_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : tb_umai_arb_afifo

`default_nettype wire

// File: logic/umai_arb_afifo.sv
`timescale 1ns/1ps
`default_nettype none

module umai_arb_afifo
  import umai_afifo_pkg::*;
(
  input  logic                    i_reset,
  input  logic                    i_bus_clk,
  input  logic                    i_ip_clk,
  input  logic                    i_ip_sel,

  // --------------------------------------------------
  // bus side, umai master
  // --------------------------------------------------
  input  logic                    i_int_mst_wcmd_valid,
  output logic                    o_int_mst_wcmd_ready,
  input  logic [CMD_ADDR_W-1:0]   i_int_mst_wcmd_addr,
  input  logic [CMD_LEN_W-1:0]    i_int_mst_wcmd_len,

  input  logic                    i_int_mst_wvalid,
  output logic                    o_int_mst_wready,
  input  logic [DATA_W-1:0]       i_int_mst_wdata,

  // --------------------------------------------------
  // ip side, one set per port
  // --------------------------------------------------
  output logic [NUM_IP_PORTS-1:0] o_ext_mst_wcmd_valid,
  input  logic [NUM_IP_PORTS-1:0] i_ext_mst_wcmd_ready,
  output logic [CMD_ADDR_W-1:0]   o_ext_mst_wcmd_addr [NUM_IP_PORTS],
  output logic [CMD_LEN_W-1:0]    o_ext_mst_wcmd_len  [NUM_IP_PORTS],

  output logic [NUM_IP_PORTS-1:0] o_ext_mst_wvalid,
  input  logic [NUM_IP_PORTS-1:0] i_ext_mst_wready,
  output logic [DATA_W-1:0]       o_ext_mst_wdata     [NUM_IP_PORTS]
);

  // command fifo
  logic                 cmd_push;
  logic                 cmd_full;
  logic [CMD_W-1:0]     cmd_push_word;
  logic                 cmd_pop;
  logic                 cmd_empty;
  logic [CMD_W-1:0]     cmd_pop_word;

  // lane fifos, shared push and pop strobes
  logic                 lane_push;
  logic [NUM_LANES-1:0] lane_full;
  logic [LANE_W-1:0]    lane_push_data [NUM_LANES];
  logic                 lane_pop;
  logic [NUM_LANES-1:0] lane_empty;
  logic [LANE_W-1:0]    lane_pop_data  [NUM_LANES];

  umai_bus_accept u_bus_accept (
    .i_wcmd_valid (i_int_mst_wcmd_valid),
    .o_wcmd_ready (o_int_mst_wcmd_ready),
    .i_wcmd_addr  (i_int_mst_wcmd_addr),
    .i_wcmd_len   (i_int_mst_wcmd_len),
    .i_wvalid     (i_int_mst_wvalid),
    .o_wready     (o_int_mst_wready),
    .i_wdata      (i_int_mst_wdata),
    .i_cmd_full   (cmd_full),
    .o_cmd_push   (cmd_push),
    .o_cmd_word   (cmd_push_word),
    .i_lane_full  (lane_full),
    .o_lane_push  (lane_push),
    .o_lane_data  (lane_push_data)
  );

  umai_async_fifo #(
    .WIDTH (CMD_W),
    .DEPTH (CMD_FIFO_DEPTH)
  ) u_wcmd_fifo (
    .i_push_clk  (i_bus_clk),
    .i_pop_clk   (i_ip_clk),
    .i_reset     (i_reset),
    .i_push      (cmd_push),
    .i_push_data (cmd_push_word),
    .o_full      (cmd_full),
    .i_pop       (cmd_pop),
    .o_empty     (cmd_empty),
    .o_pop_data  (cmd_pop_word)
  );

  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    umai_async_fifo #(
      .WIDTH (LANE_W),
      .DEPTH (DATA_FIFO_DEPTH)
    ) u_wdata_fifo (
      .i_push_clk  (i_bus_clk),
      .i_pop_clk   (i_ip_clk),
      .i_reset     (i_reset),
      .i_push      (lane_push),
      .i_push_data (lane_push_data[l]),
      .o_full      (lane_full[l]),
      .i_pop       (lane_pop),
      .o_empty     (lane_empty[l]),
      .o_pop_data  (lane_pop_data[l])
    );
  end

  umai_ip_port_steer u_port_steer (
    .i_ip_sel         (i_ip_sel),
    .i_cmd_empty      (cmd_empty),
    .i_cmd_word       (cmd_pop_word),
    .o_cmd_pop        (cmd_pop),
    .i_lane_empty     (lane_empty),
    .i_lane_data      (lane_pop_data),
    .o_lane_pop       (lane_pop),
    .o_ext_wcmd_valid (o_ext_mst_wcmd_valid),
    .i_ext_wcmd_ready (i_ext_mst_wcmd_ready),
    .o_ext_wcmd_addr  (o_ext_mst_wcmd_addr),
    .o_ext_wcmd_len   (o_ext_mst_wcmd_len),
    .o_ext_wvalid     (o_ext_mst_wvalid),
    .i_ext_wready     (i_ext_mst_wready),
    .o_ext_wdata      (o_ext_mst_wdata)
  );

endmodule : umai_arb_afifo

`default_nettype wire

// File: logic/umai_ip_port_steer.sv
`timescale 1ns/1ps
`default_nettype none

module umai_ip_port_steer
  import umai_afifo_pkg::*;
(
  input  logic                    i_ip_sel, // hold while both channels idle

  // command fifo pop side
  input  logic                    i_cmd_empty,
  input  logic [CMD_W-1:0]        i_cmd_word,
  output logic                    o_cmd_pop,

  // lane fifo pop side
  input  logic [NUM_LANES-1:0]    i_lane_empty,
  input  logic [LANE_W-1:0]       i_lane_data [NUM_LANES],
  output logic                    o_lane_pop,

  // ip ports
  output logic [NUM_IP_PORTS-1:0] o_ext_wcmd_valid,
  input  logic [NUM_IP_PORTS-1:0] i_ext_wcmd_ready,
  output logic [CMD_ADDR_W-1:0]   o_ext_wcmd_addr [NUM_IP_PORTS],
  output logic [CMD_LEN_W-1:0]    o_ext_wcmd_len  [NUM_IP_PORTS],

  output logic [NUM_IP_PORTS-1:0] o_ext_wvalid,
  input  logic [NUM_IP_PORTS-1:0] i_ext_wready,
  output logic [DATA_W-1:0]       o_ext_wdata     [NUM_IP_PORTS]
);

  logic              cmd_valid;
  logic              data_valid;
  logic [DATA_W-1:0] beat;

  assign cmd_valid  = ~i_cmd_empty;
  assign data_valid = ~|i_lane_empty; // all lanes hold the same beat

  // rejoin lanes, lane 0 low
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      beat[l*LANE_W +: LANE_W] = i_lane_data[l];
    end
  end

  // --------------------------------------------------
  // port steering
  // --------------------------------------------------
  always_comb begin
    // unselected port sees zeros
    o_ext_wcmd_valid = '0;
    o_ext_wcmd_addr  = '{default: '0};
    o_ext_wcmd_len   = '{default: '0};
    o_ext_wvalid     = '0;
    o_ext_wdata      = '{default: '0};

    o_ext_wcmd_valid[i_ip_sel] = cmd_valid;
    o_ext_wcmd_addr[i_ip_sel]  = i_cmd_word[CMD_ADDR_W-1:0];
    o_ext_wcmd_len[i_ip_sel]   = i_cmd_word[CMD_W-1:CMD_ADDR_W];

    o_ext_wvalid[i_ip_sel] = data_valid;
    o_ext_wdata[i_ip_sel]  = beat;
  end

  // pop on handshake with the selected port only
  assign o_cmd_pop  = cmd_valid & i_ext_wcmd_ready[i_ip_sel];
  assign o_lane_pop = data_valid & i_ext_wready[i_ip_sel];

endmodule : umai_ip_port_steer

`default_nettype wire

// File: logic/umai_bus_accept.sv
`timescale 1ns/1ps
`default_nettype none

module umai_bus_accept
  import umai_afifo_pkg::*;
(
  // bus side command
  input  logic                  i_wcmd_valid,
  output logic                  o_wcmd_ready,
  input  logic [CMD_ADDR_W-1:0] i_wcmd_addr,
  input  logic [CMD_LEN_W-1:0]  i_wcmd_len,

  // bus side data
  input  logic                  i_wvalid,
  output logic                  o_wready,
  input  logic [DATA_W-1:0]     i_wdata,

  // command fifo push side
  input  logic                  i_cmd_full,
  output logic                  o_cmd_push,
  output logic [CMD_W-1:0]      o_cmd_word,

  // lane fifo push side
  input  logic [NUM_LANES-1:0]  i_lane_full,
  output logic                  o_lane_push,
  output logic [LANE_W-1:0]     o_lane_data [NUM_LANES]
);

  // --------------------------------------------------
  // write command
  // --------------------------------------------------
  assign o_wcmd_ready = ~i_cmd_full;
  assign o_cmd_push   = i_wcmd_valid & o_wcmd_ready;
  assign o_cmd_word   = {i_wcmd_len, i_wcmd_addr}; // len sits above addr

  // --------------------------------------------------
  // write data
  // --------------------------------------------------
  // one full lane stalls the whole beat so the lanes never skew
  assign o_wready    = ~|i_lane_full;
  assign o_lane_push = i_wvalid & o_wready;

  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      o_lane_data[l] = i_wdata[l*LANE_W +: LANE_W];
    end
  end

endmodule : umai_bus_accept

`default_nettype wire

// File: logic/umai_async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module umai_async_fifo
  import umai_afifo_pkg::*;
#(
  parameter int WIDTH = 32,
  parameter int DEPTH = 8
) (
  input  logic             i_push_clk,
  input  logic             i_pop_clk,
  input  logic             i_reset,

  input  logic             i_push,
  input  logic [WIDTH-1:0] i_push_data,
  output logic             o_full,

  input  logic             i_pop,
  output logic             o_empty,
  output logic [WIDTH-1:0] o_pop_data
);

  localparam int AW = $clog2(DEPTH);

  // top two gray bits differ when the writer is a full lap ahead
  localparam logic [AW:0] FULL_MASK = {2'b11, {(AW-1){1'b0}}};

  logic [WIDTH-1:0] mem [DEPTH];

  logic        push_en;
  logic [AW:0] wr_bin;
  logic [AW:0] wr_bin_next;
  logic [AW:0] wr_gray;
  logic [AW:0] wr_gray_next;
  logic [AW:0] rd_gray_sync [SYNC_STAGES]; // read pointer seen by push side

  logic        pop_en;
  logic [AW:0] rd_bin;
  logic [AW:0] rd_bin_next;
  logic [AW:0] rd_gray;
  logic [AW:0] rd_gray_next;
  logic [AW:0] wr_gray_sync [SYNC_STAGES]; // write pointer seen by pop side

  // --------------------------------------------------
  // push domain
  // --------------------------------------------------
  assign push_en      = i_push & ~o_full;
  assign wr_bin_next  = wr_bin + {{AW{1'b0}}, push_en};
  assign wr_gray_next = wr_bin_next ^ (wr_bin_next >> 1);

  always_ff @(posedge i_push_clk) begin
    if (i_reset) begin
      wr_bin  <= '0;
      wr_gray <= '0;
      o_full  <= 1'b0;
    end else begin
      wr_bin  <= wr_bin_next;
      wr_gray <= wr_gray_next;
      o_full  <= (wr_gray_next == (rd_gray_sync[SYNC_STAGES-1] ^ FULL_MASK));
    end
  end

  always_ff @(posedge i_push_clk) begin
    if (i_reset) begin
      rd_gray_sync <= '{default: '0};
    end else begin
      rd_gray_sync[0] <= rd_gray;
      for (int s = 1; s < SYNC_STAGES; s++) begin
        rd_gray_sync[s] <= rd_gray_sync[s-1];
      end
    end
  end

  always_ff @(posedge i_push_clk) begin
    if (push_en) begin
      mem[wr_bin[AW-1:0]] <= i_push_data;
    end
  end

  // --------------------------------------------------
  // pop domain
  // --------------------------------------------------
  assign pop_en       = i_pop & ~o_empty;
  assign rd_bin_next  = rd_bin + {{AW{1'b0}}, pop_en};
  assign rd_gray_next = rd_bin_next ^ (rd_bin_next >> 1);

  always_ff @(posedge i_pop_clk) begin
    if (i_reset) begin
      rd_bin  <= '0;
      rd_gray <= '0;
      o_empty <= 1'b1;
    end else begin
      rd_bin  <= rd_bin_next;
      rd_gray <= rd_gray_next;
      o_empty <= (rd_gray_next == wr_gray_sync[SYNC_STAGES-1]);
    end
  end

  always_ff @(posedge i_pop_clk) begin
    if (i_reset) begin
      wr_gray_sync <= '{default: '0};
    end else begin
      wr_gray_sync[0] <= wr_gray;
      for (int s = 1; s < SYNC_STAGES; s++) begin
        wr_gray_sync[s] <= wr_gray_sync[s-1];
      end
    end
  end

  assign o_pop_data = mem[rd_bin[AW-1:0]]; // head entry, show-ahead

endmodule : umai_async_fifo

`default_nettype wire

// File: logic/umai_afifo_pkg.sv
`default_nettype none

package umai_afifo_pkg;

  // --------------------------------------------------
  // write command
  // --------------------------------------------------
  localparam int CMD_ADDR_W = 32;
  localparam int CMD_LEN_W  = 6;                      // burst length
  localparam int CMD_W      = CMD_LEN_W + CMD_ADDR_W; // {len, addr}

  // --------------------------------------------------
  // write data
  // --------------------------------------------------
  localparam int DATA_W    = 512;
  localparam int NUM_LANES = 2;
  localparam int LANE_W    = DATA_W / NUM_LANES; // lane 0 holds the low bits

  // ip side
  localparam int NUM_IP_PORTS = 2;

  // --------------------------------------------------
  // fifo sizing
  // --------------------------------------------------
  localparam int CMD_FIFO_DEPTH  = 8;
  localparam int DATA_FIFO_DEPTH = 4; // per lane
  localparam int SYNC_STAGES     = 2; // flops per gray pointer crossing

endpackage : umai_afifo_pkg

`default_nettype wire
